// File: verilog/gb_memory_map_pkg.sv
// ----------------------------------------------------------------------
// Address map of the CPU memory bus: region bounds, register addresses
// and the region codes the read selector captures with each read
// ----------------------------------------------------------------------
`default_nettype none

package gb_memory_map_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // Internal work RAM
   localparam addr_t wram_start = 16'hC000;
   localparam addr_t wram_end   = 16'hDFFF;

   // Echo of work RAM, stops short of OAM
   localparam addr_t echo_start = 16'hE000;
   localparam addr_t echo_end   = 16'hFDFF;

   // Cartridge ROM space
   localparam addr_t cart_end        = 16'h7FFF;
   // First cartridge byte visible while the boot image is mapped
   localparam addr_t cart_start_boot = 16'h0104;

   // Memory mapped registers kept on this bus
   localparam addr_t mmio_if        = 16'hFF0F;
   localparam addr_t mmio_bootstrap = 16'hFF50;
   localparam addr_t mmio_ie        = 16'hFFFF;

   // Source of a read, registered on the read edge
   typedef enum logic [1:0] {
      region_boot,
      region_cart,
      region_internal,
      region_unmapped
   } read_region_t;

endpackage

`default_nettype wire

// File: verilog/gb_interrupt_pkg.sv
// ----------------------------------------------------------------------
// Interrupt sources of the console, in IF/IE bit order
// Shared by the register block and anything that raises requests
// ----------------------------------------------------------------------
`default_nettype none

package gb_interrupt_pkg;

   localparam int int_count = 5;

   // One bit per source, same layout in IF and IE
   typedef logic [int_count-1:0] int_flags_t;

   // Bit positions, lowest index has highest priority in the CPU
   typedef enum logic [2:0] {
      int_vblank = 3'd0,
      int_lcdc   = 3'd1,
      int_timer  = 3'd2,
      int_serial = 3'd3,
      int_joypad = 3'd4
   } int_source_t;

endpackage

`default_nettype wire

// File: verilog/work_ram.sv
// ----------------------------------------------------------------------
// Work RAM with its echo window, modelled as synchronous block RAM
// Writes land on the clock edge, reads answer one cycle later with a
// hit bit that tells the read selector the byte is valid
// ----------------------------------------------------------------------
`default_nettype none

module work_ram
   import gb_memory_map_pkg::*;
#(
   parameter int unsigned wram_addr_bits = 13
) (
   input  logic  clock,
   input  logic  reset,
   input  addr_t addr,
   input  data_t wdata,
   input  logic  mem_we,
   input  logic  mem_re,
   output logic  ram_hit,
   output data_t ram_data
);

   logic                      in_wram;
   logic                      in_echo;
   logic                      in_window;
   logic                      read_edge;
   addr_t                     offset;
   logic [wram_addr_bits-1:0] index;
   data_t                     mem [0:(1 << wram_addr_bits) - 1];

   assign in_wram   = (addr >= wram_start) && (addr <= wram_end);
   assign in_echo   = (addr >= echo_start) && (addr <= echo_end);
   assign in_window = in_wram || in_echo;
   assign read_edge = mem_re && !mem_we;

   // Echo folds back onto the same cells, 0x2000 lower
   assign offset = in_echo ? addr - echo_start : addr - wram_start;
   assign index  = offset[wram_addr_bits-1:0];

   always_ff @(posedge clock) begin
      if (mem_we && in_window) begin
         mem[index] <= wdata;
      end
      if (read_edge) begin
         ram_data <= mem[index];
      end
   end

   // Valid flag for the byte above
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ram_hit <= 1'b0;
      end else if (read_edge) begin
         ram_hit <= in_window;
      end
   end

endmodule

`default_nettype wire

// File: verilog/io_registers.sv
// ----------------------------------------------------------------------
// Bootstrap, interrupt flag and interrupt enable registers
// Request pulses set IF bits that stay until the CPU writes IF; bit 0
// of the bootstrap register unmaps the boot flash for good
// ----------------------------------------------------------------------
`default_nettype none

module io_registers
   import gb_memory_map_pkg::*;
   import gb_interrupt_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  logic       mem_we,
   input  logic       mem_re,
   input  addr_t      addr,
   input  data_t      wdata,
   input  int_flags_t int_req,
   output logic       io_hit,
   output data_t      io_data,
   output int_flags_t int_flags,
   output int_flags_t int_enable,
   output logic       boot_done
);

   data_t      bootstrap;
   logic       sel_bootstrap;
   logic       sel_if;
   logic       sel_ie;
   logic       read_edge;
   int_flags_t req_masked;
   data_t      read_value;

   assign sel_bootstrap = (addr == mmio_bootstrap);
   assign sel_if        = (addr == mmio_if);
   assign sel_ie        = (addr == mmio_ie);
   assign read_edge     = mem_re && !mem_we;
   assign boot_done     = bootstrap[0];

   // No serial port here, so only a CPU write can raise that flag
   always_comb begin
      req_masked             = int_req;
      req_masked[int_serial] = 1'b0;
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         bootstrap  <= '0;
         int_flags  <= '0;
         int_enable <= '0;
      end else begin
         if (mem_we && sel_bootstrap) begin
            bootstrap <= wdata;
         end
         // Same-cycle requests win over the written value
         if (mem_we && sel_if) begin
            int_flags <= wdata[int_count-1:0] | req_masked;
         end else begin
            int_flags <= int_flags | req_masked;
         end
         if (mem_we && sel_ie) begin
            int_enable <= wdata[int_count-1:0];
         end
      end
   end

   // Upper bits of IF and IE read as zero
   always_comb begin
      read_value = '0;
      if (sel_bootstrap) begin
         read_value = bootstrap;
      end else if (sel_if) begin
         read_value = data_t'(int_flags);
      end else if (sel_ie) begin
         read_value = data_t'(int_enable);
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         io_hit <= 1'b0;
      end else if (read_edge) begin
         io_hit <= sel_bootstrap || sel_if || sel_ie;
      end
   end

   always_ff @(posedge clock) begin
      if (read_edge) begin
         io_data <= read_value;
      end
   end

endmodule

`default_nettype wire

// File: verilog/bus_read_select.sv
// ----------------------------------------------------------------------
// Read selector for the CPU bus
// Classifies each read as boot flash, cartridge, internal or unmapped,
// captures the external byte on the read edge and merges it with the
// work RAM and register results one cycle later
// ----------------------------------------------------------------------
`default_nettype none

module bus_read_select
   import gb_memory_map_pkg::*;
#(
   parameter addr_t boot_rom_end = 16'h0103
) (
   input  logic  clock,
   input  logic  reset,
   input  logic  mem_we,
   input  logic  mem_re,
   input  logic  boot_done,
   input  logic  ram_hit,
   input  logic  io_hit,
   input  addr_t addr,
   input  data_t boot_data,
   input  data_t cart_data,
   input  data_t ram_data,
   input  data_t io_data,
   output data_t rdata,
   output addr_t boot_addr
);

   logic         in_boot;
   logic         in_cart;
   logic         in_internal;
   logic         read_edge;
   read_region_t region;
   read_region_t region_q;
   data_t        ext_data;
   data_t        ext_q;

   assign read_edge = mem_re && !mem_we;

   // Flash covers the low bytes until the bootstrap bit is set
   assign in_boot = !boot_done && (addr < boot_rom_end);
   assign in_cart = (addr <= cart_end) && (boot_done || (addr >= cart_start_boot));

   assign in_internal = ((addr >= wram_start) && (addr <= wram_end))
                     || ((addr >= echo_start) && (addr <= echo_end))
                     || (addr == mmio_bootstrap)
                     || (addr == mmio_if)
                     || (addr == mmio_ie);

   always_comb begin
      if (in_boot) begin
         region = region_boot;
      end else if (in_cart) begin
         region = region_cart;
      end else if (in_internal) begin
         region = region_internal;
      end else begin
         region = region_unmapped;
      end
   end

   assign ext_data = in_boot ? boot_data : cart_data;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         region_q <= region_unmapped;
      end else if (read_edge) begin
         region_q <= region;
      end
   end

   // External byte sampled with its region
   always_ff @(posedge clock) begin
      if (read_edge) begin
         ext_q <= ext_data;
      end
   end

   // Everything here comes from state captured on the last read
   always_comb begin
      case (region_q)
         region_boot, region_cart: begin
            rdata = ext_q;
         end
         region_internal: begin
            if (ram_hit) begin
               rdata = ram_data;
            end else if (io_hit) begin
               rdata = io_data;
            end else begin
               rdata = '0;
            end
         end
         default: begin
            rdata = '0;
         end
      endcase
   end

   assign boot_addr = addr;

endmodule

`default_nettype wire

// File: verilog/gb_bus_top.sv
// ----------------------------------------------------------------------
// CPU-facing memory bus of the console
// Work RAM and the I/O registers decode in parallel; the read selector
// adds boot flash and cartridge bytes and drives the read data
// ----------------------------------------------------------------------
`default_nettype none

module gb_bus_top
   import gb_memory_map_pkg::*;
   import gb_interrupt_pkg::*;
#(
   parameter int unsigned wram_addr_bits = 13,
   parameter addr_t       boot_rom_end   = 16'h0103
) (
   input  logic       clock,
   input  logic       reset,
   input  addr_t      addr,
   input  data_t      wdata,
   input  logic       mem_we,
   input  logic       mem_re,
   input  data_t      boot_data,
   input  data_t      cart_data,
   input  int_flags_t int_req,
   output data_t      rdata,
   output int_flags_t int_flags,
   output int_flags_t int_enable,
   output logic       boot_done,
   output addr_t      boot_addr
);

   logic  ram_hit;
   data_t ram_data;
   logic  io_hit;
   data_t io_data;

   work_ram #(
      .wram_addr_bits (wram_addr_bits)
   ) u_work_ram (
      .clock    (clock),
      .reset    (reset),
      .addr     (addr),
      .wdata    (wdata),
      .mem_we   (mem_we),
      .mem_re   (mem_re),
      .ram_hit  (ram_hit),
      .ram_data (ram_data)
   );

   io_registers u_io_registers (
      .clock      (clock),
      .reset      (reset),
      .mem_we     (mem_we),
      .mem_re     (mem_re),
      .addr       (addr),
      .wdata      (wdata),
      .int_req    (int_req),
      .io_hit     (io_hit),
      .io_data    (io_data),
      .int_flags  (int_flags),
      .int_enable (int_enable),
      .boot_done  (boot_done)
   );

   bus_read_select #(
      .boot_rom_end (boot_rom_end)
   ) u_bus_read_select (
      .clock     (clock),
      .reset     (reset),
      .mem_we    (mem_we),
      .mem_re    (mem_re),
      .boot_done (boot_done),
      .ram_hit   (ram_hit),
      .io_hit    (io_hit),
      .addr      (addr),
      .boot_data (boot_data),
      .cart_data (cart_data),
      .ram_data  (ram_data),
      .io_data   (io_data),
      .rdata     (rdata),
      .boot_addr (boot_addr)
   );

endmodule

`default_nettype wire

// File: dv/gb_bus_tb.sv
// ----------------------------------------------------------------------
// Testbench for the CPU memory bus
// Reads bus operations from dv/gb_bus_vectors.txt, drives them on the
// falling clock edge and checks read data and register outputs
// ----------------------------------------------------------------------
`default_nettype none

module gb_bus_tb
   import gb_memory_map_pkg::*;
   import gb_interrupt_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   logic       clock;
   logic       reset;
   addr_t      addr;
   data_t      wdata;
   logic       mem_we;
   logic       mem_re;
   data_t      boot_data;
   data_t      cart_data;
   int_flags_t int_req;
   data_t      rdata;
   int_flags_t int_flags;
   int_flags_t int_enable;
   logic       boot_done;
   addr_t      boot_addr;

   // Parsed vector columns
   int    test_q[$];
   string op_q[$];
   string addr_q[$];
   string data_q[$];
   string exp_q[$];

   // Expected contents of work RAM, keyed by offset from 0xC000
   data_t      ram_model [addr_t];
   logic       boot_model;
   int_flags_t pending_req;
   int         cycles;
   int         cycle_limit;
   int         errors;
   int         checks;
   int         tests_run;
   int         test_errors;
   int         test_checks;
   int         current_test;

   gb_bus_top u_dut (
      .clock      (clock),
      .reset      (reset),
      .addr       (addr),
      .wdata      (wdata),
      .mem_we     (mem_we),
      .mem_re     (mem_re),
      .boot_data  (boot_data),
      .cart_data  (cart_data),
      .int_req    (int_req),
      .rdata      (rdata),
      .int_flags  (int_flags),
      .int_enable (int_enable),
      .boot_done  (boot_done),
      .boot_addr  (boot_addr)
   );

   // Stand-ins for the boot flash and cartridge contents
   function automatic data_t flash_byte(input addr_t a);
      return a[7:0] ^ 8'hA5;
   endfunction

   function automatic data_t cart_byte(input addr_t a);
      return a[7:0] ^ 8'h3C;
   endfunction

   assign boot_data = flash_byte(addr);
   assign cart_data = cart_byte(addr);

   function automatic data_t expected_read(input addr_t a);
      addr_t key;
      data_t value;
      value = 8'h00;
      key   = 16'h0000;
      if (a >= wram_start && a <= wram_end) begin
         key = a - wram_start;
      end else if (a >= echo_start && a <= echo_end) begin
         key = a - echo_start;
      end
      if ((a >= wram_start && a <= wram_end) || (a >= echo_start && a <= echo_end)) begin
         if (ram_model.exists(key)) begin
            value = ram_model[key];
         end
      end else if (!boot_model && a < 16'h0103) begin
         value = flash_byte(a);
      end else if (a <= cart_end && (boot_model || a >= cart_start_boot)) begin
         value = cart_byte(a);
      end
      return value;
   endfunction

   task automatic compare_value(input string name, input data_t actual, input data_t expected);
      checks++;
      test_checks++;
      assert (actual === expected) else begin
         $display("[FAIL] time %0t: %s expected %02h, got %02h", $time, name, expected, actual);
         errors++;
         test_errors++;
      end
   endtask

   task automatic compare_address(input string name, input addr_t actual, input addr_t expected);
      checks++;
      test_checks++;
      assert (actual === expected) else begin
         $display("[FAIL] time %0t: %s expected %04h, got %04h", $time, name, expected, actual);
         errors++;
         test_errors++;
      end
   endtask

   task automatic load_vectors(output int ok);
      int    fd;
      int    count;
      int    tnum;
      string line;
      string op;
      string a_s;
      string d_s;
      string e_s;
      fd = $fopen("dv/gb_bus_vectors.txt", "r");
      ok = (fd != 0) ? 1 : 0;
      if (fd != 0) begin
         while ($fgets(line, fd) > 0) begin
            count = $sscanf(line, "%d %s %s %s %s", tnum, op, a_s, d_s, e_s);
            if (line[0] != "#" && count == 5) begin
               test_q.push_back(tnum);
               op_q.push_back(op);
               addr_q.push_back(a_s);
               data_q.push_back(d_s);
               exp_q.push_back(e_s);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic report_test();
      tests_run++;
      $display("test %0d: %0d checks, %0d errors", current_test, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   // Called on a falling edge, returns on a falling edge
   task automatic run_vector(input int idx);
      string op;
      addr_t a;
      data_t d;
      data_t exp_value;
      op        = op_q[idx];
      a         = addr_t'(addr_q[idx].atohex());
      d         = data_t'(data_q[idx].atohex());
      exp_value = data_t'(exp_q[idx].atohex());
      if (data_q[idx] == "rand") begin
         d = data_t'($urandom);
      end
      if (exp_q[idx] == "computed") begin
         exp_value = expected_read(a);
      end
      if (op == "request") begin
         // Pulse goes out with the next bus cycle
         pending_req = int_flags_t'(d);
      end else begin
         addr        = a;
         wdata       = d;
         mem_we      = (op == "write");
         mem_re      = (op == "read");
         int_req     = pending_req;
         pending_req = '0;
         if (op == "write") begin
            if (a >= wram_start && a <= wram_end) begin
               ram_model[a - wram_start] = d;
            end else if (a >= echo_start && a <= echo_end) begin
               ram_model[a - echo_start] = d;
            end else if (a == mmio_bootstrap) begin
               boot_model = d[0];
            end
         end
         @(posedge clock);
         @(negedge clock);
         mem_we  = 1'b0;
         mem_re  = 1'b0;
         int_req = '0;
         case (op)
            "read", "rdata": compare_value("rdata", rdata, exp_value);
            "flags":         compare_value("int_flags", data_t'(int_flags), exp_value);
            "enable":        compare_value("int_enable", data_t'(int_enable), exp_value);
            "boot":          compare_value("boot_done", data_t'(boot_done), exp_value);
            "write":         ;
            default: begin
               $display("Vector %0d has an unknown operation '%s'", idx, op);
               errors++;
               test_errors++;
            end
         endcase
         // Flash address follows the bus address
         compare_address("boot_addr", boot_addr, a);
      end
   endtask

   initial begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   // Watchdog
   always @(posedge clock) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Run stopped after %0d cycles without finishing the vectors", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      int ok;
      void'($urandom(32'hf32615b7));
      reset       = 1'b1;
      addr        = '0;
      wdata       = '0;
      mem_we      = 1'b0;
      mem_re      = 1'b0;
      int_req     = '0;
      pending_req = '0;
      boot_model  = 1'b0;
      cycles      = 0;
      cycle_limit = 100;
      errors      = 0;
      checks      = 0;
      tests_run   = 0;
      test_errors = 0;
      test_checks = 0;
      load_vectors(ok);
      cycle_limit = 10 * test_q.size() + 100;
      if (ok == 0) begin
         $display("Could not open dv/gb_bus_vectors.txt for reading");
         $display("*** TEST FAILED ***");
         $finish;
      end else begin
         repeat (5) @(posedge clock);
         @(negedge clock);
         reset = 1'b0;
         if (test_q.size() > 0) begin
            current_test = test_q[0];
         end
         for (int i = 0; i < test_q.size(); i++) begin
            if (test_q[i] != current_test) begin
               report_test();
               current_test = test_q[i];
            end
            run_vector(i);
         end
         report_test();
         $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
         if (errors == 0 && checks > 0) begin
            $display("*** TEST PASSED ***");
         end else begin
            $display("*** TEST FAILED ***");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: dv/gb_bus_vectors.txt
# test op addr data expect | hex fields, '-' unused; 'request' arms int_req for the next line
# ops: write read request rdata flags enable boot; data 'rand' and expect 'computed' come from the testbench
1 rdata    -    -    00
1 flags    -    -    00
1 enable   -    -    00
1 boot     -    -    00
2 write    c000 rand -
2 write    dfff rand -
2 read     c000 -    computed
2 read     dfff -    computed
2 write    e123 rand -
2 read     c123 -    computed
2 write    c456 rand -
2 read     e456 -    computed
3 read     0042 -    computed
3 read     0103 -    00
3 read     0200 -    computed
3 boot     -    -    00
3 write    ff50 01   -
3 boot     -    -    01
3 read     0042 -    computed
3 read     ff50 -    01
4 request  -    05   -
4 flags    -    -    05
4 flags    -    -    05
4 read     ff0f -    05
4 write    ff0f e0   -
4 flags    -    -    00
4 read     ff0f -    00
4 request  -    10   -
4 write    ff0f 00   -
4 flags    -    -    10
5 write    ffff ff   -
5 enable   -    -    1f
5 read     ffff -    1f
5 read     ff10 -    00
5 read     ff40 -    00
5 read     8000 -    00

// File: gb_bus.f
verilog/gb_memory_map_pkg.sv
verilog/gb_interrupt_pkg.sv
verilog/work_ram.sv
verilog/io_registers.sv
verilog/bus_read_select.sv
verilog/gb_bus_top.sv
dv/gb_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the bus testbench with Verilator and run it.
# The result is taken from the simulation log.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module gb_bus_tb \
   -f gb_bus.f

./obj_dir/Vgb_bus_tb 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
   exit 1
fi
exit 0
